// File: Bender.yml
package:
  name: echo_app

sources:
  - common/echo_noc_pkg.sv
  - common/echo_app_pkg.sv
  - flow_state/flow_state_arb.sv
  - flow_state/flow_state_mem.sv
  - logic/echo_app_new_flow_notif.sv
  - logic/echo_app_rx_data_notif.sv
  - logic/echo_app_active_q.sv
  - logic/echo_app_tx_sched.sv
  - logic/echo_app_top.sv
  - target: test
    files:
      - tests/echo_app_checker.sv
      - tests/echo_app_tb.sv

// File: common/echo_app_pkg.sv
package echo_app_pkg;

    localparam int NUM_FLOWS = 2 ** echo_noc_pkg::FLOWID_W;

    // one slot per flow, so a registered flow always fits.
    localparam int ACTIVE_Q_DEPTH = 16;
    localparam int ACTIVE_Q_PTR_W = 4;

    // client 0 is the data notification receiver, client 1 the scheduler.
    localparam int NUM_FLOW_CLIENTS = 2;

    typedef enum logic {
        FLOW_ADD        = 1'b0,
        FLOW_READ_CLEAR = 1'b1
    } flow_op_e;

    typedef struct packed {
        flow_op_e               op;
        echo_noc_pkg::flowid_t  flowid;
        echo_noc_pkg::len_t     len;
    } flow_req_t;

endpackage

// File: common/echo_noc_pkg.sv
package echo_noc_pkg;

    localparam int NOC_DATA_W = 64;
    localparam int FLOWID_W = 4;
    localparam int LEN_W = 16;
    localparam int MSG_TYPE_W = 8;

    // bits left over in a header flit after the used fields.
    localparam int HDR_PAD_W = NOC_DATA_W - MSG_TYPE_W - FLOWID_W - LEN_W;

    typedef logic [NOC_DATA_W-1:0] noc_data_t;
    typedef logic [FLOWID_W-1:0] flowid_t;
    typedef logic [LEN_W-1:0] len_t;

    typedef enum logic [MSG_TYPE_W-1:0] {
        MSG_NEW_FLOW = 8'h01,
        MSG_RX_DATA  = 8'h02,
        MSG_TX_CMD   = 8'h03
    } noc_msg_e;

    // msg_type sits in the top byte of the flit.
    typedef struct packed {
        noc_msg_e               msg_type;
        flowid_t                flowid;
        len_t                   length;
        logic [HDR_PAD_W-1:0]   padding;
    } noc_hdr_flit_t;

endpackage

// File: flow_state/flow_state_arb.sv
`timescale 1ns/1ps
module flow_state_arb (
     input  logic                                       clk
    ,input  logic                                       rst

    ,input  logic [echo_app_pkg::NUM_FLOW_CLIENTS-1:0]  req
    ,input  echo_app_pkg::flow_req_t                    req_data_0
    ,input  echo_app_pkg::flow_req_t                    req_data_1
    ,output logic [echo_app_pkg::NUM_FLOW_CLIENTS-1:0]  gnt

    ,output logic                                       mem_en
    ,output echo_app_pkg::flow_req_t                    mem_req
);

    // index of the client that wins a tie.
    logic prio_reg;

    always_comb begin
        gnt = '0;
        if (req[prio_reg]) begin
            gnt[prio_reg] = 1'b1;
        end else if (req[~prio_reg]) begin
            gnt[~prio_reg] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prio_reg <= 1'b0;
        end else if (|gnt) begin
            prio_reg <= gnt[0];
        end
    end

    assign mem_en = |gnt;
    assign mem_req = gnt[1] ? req_data_1 : req_data_0;

    a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt));

    // a client passed over once wins on the next cycle.
    for (genvar i = 0; i < echo_app_pkg::NUM_FLOW_CLIENTS; i++) begin : g_fair
        a_no_starve: assert property (@(posedge clk) disable iff (rst)
            req[i] && !gnt[i] |=> gnt[i]);
    end

endmodule

// File: flow_state/flow_state_mem.sv
`timescale 1ns/1ps
module flow_state_mem (
     input  logic                       clk
    ,input  logic                       rst

    ,input  logic                       en
    ,input  echo_app_pkg::flow_req_t    op_req
    ,output echo_noc_pkg::len_t         rd_data
);

    echo_noc_pkg::len_t pending [echo_app_pkg::NUM_FLOWS];

    // one extra bit to catch a wrap.
    logic [echo_noc_pkg::LEN_W:0] add_sum;

    assign add_sum = {1'b0, pending[op_req.flowid]} + {1'b0, op_req.len};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < echo_app_pkg::NUM_FLOWS; i++) begin
                pending[i] <= '0;
            end
        end else if (en) begin
            if (op_req.op == echo_app_pkg::FLOW_ADD) begin
                pending[op_req.flowid] <= add_sum[echo_noc_pkg::LEN_W-1:0];
            end else begin
                pending[op_req.flowid] <= '0;
            end
        end
    end

    // old count, seen by the requester one cycle after its grant.
    always_ff @(posedge clk) begin
        if (en) begin
            rd_data <= pending[op_req.flowid];
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        en && (op_req.op == echo_app_pkg::FLOW_ADD) |-> !add_sum[echo_noc_pkg::LEN_W]);

endmodule

// File: logic/echo_app_active_q.sv
`timescale 1ns/1ps
module echo_app_active_q (
     input  logic                       clk
    ,input  logic                       rst

    ,input  logic                       push0
    ,input  echo_noc_pkg::flowid_t      push0_flowid
    ,input  logic                       push1
    ,input  echo_noc_pkg::flowid_t      push1_flowid

    ,input  logic                       pop
    ,output echo_noc_pkg::flowid_t      head_flowid
    ,output logic                       empty
);

    typedef logic [echo_app_pkg::ACTIVE_Q_PTR_W-1:0] ptr_t;
    typedef logic [echo_app_pkg::ACTIVE_Q_PTR_W:0] cnt_t;

    echo_noc_pkg::flowid_t slots [echo_app_pkg::ACTIVE_Q_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic full;

    assign empty = (count == '0);
    assign full = (count == cnt_t'(echo_app_pkg::ACTIVE_Q_DEPTH));
    assign head_flowid = slots[rd_ptr];

    // port 0 takes the first free slot when both ports push together.
    always_ff @(posedge clk) begin
        if (push0) begin
            slots[wr_ptr] <= push0_flowid;
        end
        if (push1) begin
            slots[wr_ptr + ptr_t'(push0)] <= push1_flowid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            wr_ptr <= wr_ptr + ptr_t'(push0) + ptr_t'(push1);
            rd_ptr <= rd_ptr + ptr_t'(pop);
            count <= count + cnt_t'(push0) + cnt_t'(push1) - cnt_t'(pop);
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        (push0 || push1) |-> !full);

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty);

endmodule

// File: logic/echo_app_new_flow_notif.sv
`timescale 1ns/1ps
module echo_app_new_flow_notif (
     input  logic                       clk
    ,input  logic                       rst

    ,input  logic                       new_flow_val
    ,input  echo_noc_pkg::noc_data_t    new_flow_data
    ,output logic                       new_flow_rdy

    ,output logic                       active_q_push
    ,output echo_noc_pkg::flowid_t      active_q_push_flowid
);

    typedef enum logic {
        READY      = 1'b0,
        WRITE_FIFO = 1'b1
    } state_e;

    state_e state_reg;
    state_e state_next;

    echo_noc_pkg::noc_hdr_flit_t hdr_flit_cast;

    echo_noc_pkg::flowid_t flowid_reg;

    logic store_flowid;

    assign hdr_flit_cast = new_flow_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= READY;
        end else begin
            state_reg <= state_next;
        end
    end

    // flowid follows the input while ready and freezes after the accept.
    always_ff @(posedge clk) begin
        if (store_flowid) begin
            flowid_reg <= hdr_flit_cast.flowid;
        end
    end

    assign active_q_push_flowid = flowid_reg;

    always_comb begin
        new_flow_rdy = 1'b0;
        active_q_push = 1'b0;
        store_flowid = 1'b0;
        state_next = state_reg;
        case (state_reg)
            READY: begin
                new_flow_rdy = 1'b1;
                store_flowid = 1'b1;
                if (new_flow_val) begin
                    state_next = WRITE_FIFO;
                end
            end
            WRITE_FIFO: begin
                active_q_push = 1'b1;
                state_next = READY;
            end
            default: begin
                state_next = READY;
            end
        endcase
    end

endmodule

// File: logic/echo_app_rx_data_notif.sv
`timescale 1ns/1ps
module echo_app_rx_data_notif (
     input  logic                       clk
    ,input  logic                       rst

    ,input  logic                       rx_data_val
    ,input  echo_noc_pkg::noc_data_t    rx_data_data
    ,output logic                       rx_data_rdy

    ,output logic                       req
    ,output echo_app_pkg::flow_req_t    req_data
    ,input  logic                       gnt
);

    typedef enum logic {
        IDLE = 1'b0,
        REQ  = 1'b1
    } state_e;

    state_e state_reg;
    state_e state_next;

    echo_noc_pkg::noc_hdr_flit_t hdr_flit_cast;

    echo_noc_pkg::flowid_t flowid_reg;
    echo_noc_pkg::len_t len_reg;

    assign hdr_flit_cast = rx_data_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= IDLE;
        end else begin
            state_reg <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if ((state_reg == IDLE) && rx_data_val) begin
            flowid_reg <= hdr_flit_cast.flowid;
            len_reg <= hdr_flit_cast.length;
        end
    end

    // the add request stays steady until the arbiter picks it.
    assign req_data.op = echo_app_pkg::FLOW_ADD;
    assign req_data.flowid = flowid_reg;
    assign req_data.len = len_reg;

    always_comb begin
        rx_data_rdy = 1'b0;
        req = 1'b0;
        state_next = state_reg;
        case (state_reg)
            IDLE: begin
                rx_data_rdy = 1'b1;
                if (rx_data_val) begin
                    state_next = REQ;
                end
            end
            REQ: begin
                req = 1'b1;
                if (gnt) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

// File: logic/echo_app_top.sv
`timescale 1ns/1ps
module echo_app_top (
     input  logic                       clk
    ,input  logic                       rst

    ,input  logic                       new_flow_val
    ,input  echo_noc_pkg::noc_data_t    new_flow_data
    ,output logic                       new_flow_rdy

    ,input  logic                       rx_data_val
    ,input  echo_noc_pkg::noc_data_t    rx_data_data
    ,output logic                       rx_data_rdy

    ,output logic                       tx_cmd_val
    ,output echo_noc_pkg::noc_data_t    tx_cmd_data
    ,input  logic                       tx_cmd_rdy
);

    logic                       nf_push;
    echo_noc_pkg::flowid_t      nf_push_flowid;

    logic                       sched_pop;
    logic                       sched_push;
    echo_noc_pkg::flowid_t      sched_push_flowid;
    echo_noc_pkg::flowid_t      q_head;
    logic                       q_empty;

    logic [echo_app_pkg::NUM_FLOW_CLIENTS-1:0] client_req;
    logic [echo_app_pkg::NUM_FLOW_CLIENTS-1:0] client_gnt;
    echo_app_pkg::flow_req_t    rx_req_data;
    echo_app_pkg::flow_req_t    sched_req_data;

    logic                       mem_en;
    echo_app_pkg::flow_req_t    mem_req;
    echo_noc_pkg::len_t         mem_rd_data;

    echo_app_new_flow_notif new_flow_notif (
         .clk                   (clk)
        ,.rst                   (rst)
        ,.new_flow_val          (new_flow_val)
        ,.new_flow_data         (new_flow_data)
        ,.new_flow_rdy          (new_flow_rdy)
        ,.active_q_push         (nf_push)
        ,.active_q_push_flowid  (nf_push_flowid)
    );

    echo_app_rx_data_notif rx_data_notif (
         .clk           (clk)
        ,.rst           (rst)
        ,.rx_data_val   (rx_data_val)
        ,.rx_data_data  (rx_data_data)
        ,.rx_data_rdy   (rx_data_rdy)
        ,.req           (client_req[0])
        ,.req_data      (rx_req_data)
        ,.gnt           (client_gnt[0])
    );

    echo_app_active_q active_q (
         .clk           (clk)
        ,.rst           (rst)
        ,.push0         (nf_push)
        ,.push0_flowid  (nf_push_flowid)
        ,.push1         (sched_push)
        ,.push1_flowid  (sched_push_flowid)
        ,.pop           (sched_pop)
        ,.head_flowid   (q_head)
        ,.empty         (q_empty)
    );

    echo_app_tx_sched tx_sched (
         .clk           (clk)
        ,.rst           (rst)
        ,.q_empty       (q_empty)
        ,.q_head        (q_head)
        ,.q_pop         (sched_pop)
        ,.q_push        (sched_push)
        ,.q_push_flowid (sched_push_flowid)
        ,.req           (client_req[1])
        ,.req_data      (sched_req_data)
        ,.gnt           (client_gnt[1])
        ,.rd_data       (mem_rd_data)
        ,.tx_cmd_val    (tx_cmd_val)
        ,.tx_cmd_data   (tx_cmd_data)
        ,.tx_cmd_rdy    (tx_cmd_rdy)
    );

    flow_state_arb arb (
         .clk           (clk)
        ,.rst           (rst)
        ,.req           (client_req)
        ,.req_data_0    (rx_req_data)
        ,.req_data_1    (sched_req_data)
        ,.gnt           (client_gnt)
        ,.mem_en        (mem_en)
        ,.mem_req       (mem_req)
    );

    flow_state_mem flow_mem (
         .clk       (clk)
        ,.rst       (rst)
        ,.en        (mem_en)
        ,.op_req    (mem_req)
        ,.rd_data   (mem_rd_data)
    );

endmodule

// File: logic/echo_app_tx_sched.sv
`timescale 1ns/1ps
module echo_app_tx_sched (
     input  logic                       clk
    ,input  logic                       rst

    ,input  logic                       q_empty
    ,input  echo_noc_pkg::flowid_t      q_head
    ,output logic                       q_pop
    ,output logic                       q_push
    ,output echo_noc_pkg::flowid_t      q_push_flowid

    ,output logic                       req
    ,output echo_app_pkg::flow_req_t    req_data
    ,input  logic                       gnt
    ,input  echo_noc_pkg::len_t         rd_data

    ,output logic                       tx_cmd_val
    ,output echo_noc_pkg::noc_data_t    tx_cmd_data
    ,input  logic                       tx_cmd_rdy
);

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        REQ     = 3'd1,
        CAPTURE = 3'd2,
        SEND    = 3'd3,
        REQUEUE = 3'd4
    } state_e;

    state_e state_reg;
    state_e state_next;

    echo_noc_pkg::flowid_t flowid_reg;
    echo_noc_pkg::len_t len_reg;

    echo_noc_pkg::noc_hdr_flit_t cmd_hdr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= IDLE;
        end else begin
            state_reg <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            flowid_reg <= q_head;
        end
        if (state_reg == CAPTURE) begin
            len_reg <= rd_data;
        end
    end

    assign req_data.op = echo_app_pkg::FLOW_READ_CLEAR;
    assign req_data.flowid = flowid_reg;
    assign req_data.len = '0;

    assign q_push_flowid = flowid_reg;

    assign cmd_hdr.msg_type = echo_noc_pkg::MSG_TX_CMD;
    assign cmd_hdr.flowid = flowid_reg;
    assign cmd_hdr.length = len_reg;
    assign cmd_hdr.padding = '0;
    assign tx_cmd_data = cmd_hdr;

    always_comb begin
        q_pop = 1'b0;
        q_push = 1'b0;
        req = 1'b0;
        tx_cmd_val = 1'b0;
        state_next = state_reg;
        case (state_reg)
            IDLE: begin
                if (!q_empty) begin
                    q_pop = 1'b1;
                    state_next = REQ;
                end
            end
            REQ: begin
                req = 1'b1;
                if (gnt) begin
                    state_next = CAPTURE;
                end
            end
            CAPTURE: begin
                // nothing pending means nothing to echo this turn.
                state_next = (rd_data != '0) ? SEND : REQUEUE;
            end
            SEND: begin
                tx_cmd_val = 1'b1;
                if (tx_cmd_rdy) begin
                    state_next = REQUEUE;
                end
            end
            REQUEUE: begin
                q_push = 1'b1;
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
        tx_cmd_val && !tx_cmd_rdy |=> tx_cmd_val && $stable(tx_cmd_data));

endmodule

// File: tb.f
common/echo_noc_pkg.sv
common/echo_app_pkg.sv
flow_state/flow_state_arb.sv
flow_state/flow_state_mem.sv
logic/echo_app_new_flow_notif.sv
logic/echo_app_rx_data_notif.sv
logic/echo_app_active_q.sv
logic/echo_app_tx_sched.sv
logic/echo_app_top.sv
tests/echo_app_checker.sv
tests/echo_app_tb.sv

// File: tests/echo_app_checker.sv
`timescale 1ns/1ps
module echo_app_checker (
     input  logic                       clk
    ,input  logic                       rst

    ,input  logic                       new_flow_val
    ,input  echo_noc_pkg::noc_data_t    new_flow_data
    ,input  logic                       new_flow_rdy

    ,input  logic                       rx_data_val
    ,input  echo_noc_pkg::noc_data_t    rx_data_data
    ,input  logic                       rx_data_rdy

    ,input  logic                       tx_cmd_val
    ,input  echo_noc_pkg::noc_data_t    tx_cmd_data
    ,input  logic                       tx_cmd_rdy

    ,input  logic                       final_check
    ,output int                         check_count
    ,output int                         error_count
);

    // the arbiter grants a waiting client within two cycles.
    localparam int RX_RDY_LOW_MAX = 2;

    echo_noc_pkg::noc_hdr_flit_t nf_hdr;
    echo_noc_pkg::noc_hdr_flit_t rx_hdr;
    echo_noc_pkg::noc_hdr_flit_t tx_hdr;

    logic registered [echo_app_pkg::NUM_FLOWS];
    int unsigned rx_total [echo_app_pkg::NUM_FLOWS];
    int unsigned tx_total [echo_app_pkg::NUM_FLOWS];

    int checks = 0;
    int errors = 0;
    logic rst_q = 1'b0;
    logic nf_acc_d1;
    logic nf_acc_d2;
    logic tx_stall_q;
    echo_noc_pkg::noc_data_t tx_data_q;
    int rx_low_run;

    assign nf_hdr = new_flow_data;
    assign rx_hdr = rx_data_data;
    assign tx_hdr = tx_cmd_data;
    assign check_count = checks;
    assign error_count = errors;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error [%s]: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        if (cond !== 1'b1) begin
            errors++;
            $display("** Error: %s", what);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < echo_app_pkg::NUM_FLOWS; i++) begin
                registered[i] = 1'b0;
                rx_total[i] = 0;
                tx_total[i] = 0;
            end
            nf_acc_d1 = 1'b0;
            nf_acc_d2 = 1'b0;
            tx_stall_q = 1'b0;
            rx_low_run = 0;
        end else begin
            if (rst_q) begin
                check_value("reset tx_cmd_val", 64'd0, 64'(tx_cmd_val));
                check_value("reset new_flow_rdy", 64'd1, 64'(new_flow_rdy));
                check_value("reset rx_data_rdy", 64'd1, 64'(rx_data_rdy));
            end
            // rdy drops for exactly one cycle after each new-flow accept.
            if (nf_acc_d1) begin
                check_value("new_flow_rdy after accept", 64'd0, 64'(new_flow_rdy));
            end
            if (nf_acc_d2) begin
                check_value("new_flow_rdy recovery", 64'd1, 64'(new_flow_rdy));
            end
            nf_acc_d2 = nf_acc_d1;
            nf_acc_d1 = new_flow_val && new_flow_rdy;
            if (new_flow_val && new_flow_rdy) begin
                registered[nf_hdr.flowid] = 1'b1;
            end

            if (rx_data_val && rx_data_rdy) begin
                rx_total[rx_hdr.flowid] += rx_hdr.length;
            end
            rx_low_run = rx_data_rdy ? 0 : rx_low_run + 1;
            check_true(rx_low_run != RX_RDY_LOW_MAX + 1,
                       "rx_data_rdy stayed low longer than the arbitration bound");

            if (tx_stall_q) begin
                check_value("tx_cmd_val held while stalled", 64'd1, 64'(tx_cmd_val));
                check_value("tx_cmd_data held while stalled", tx_data_q, tx_cmd_data);
            end
            if (tx_cmd_val && tx_cmd_rdy) begin
                check_value("tx_cmd msg_type", 64'(echo_noc_pkg::MSG_TX_CMD),
                            64'(tx_hdr.msg_type));
                check_true(tx_hdr.length != '0, "a transmit command carried a zero length");
                check_true(registered[tx_hdr.flowid],
                           $sformatf("a transmit command named unregistered flow %0d",
                                     tx_hdr.flowid));
                tx_total[tx_hdr.flowid] += tx_hdr.length;
            end
            tx_stall_q = tx_cmd_val && !tx_cmd_rdy;
            tx_data_q = tx_cmd_data;

            if (final_check) begin
                for (int i = 0; i < echo_app_pkg::NUM_FLOWS; i++) begin
                    if (registered[i]) begin
                        check_value($sformatf("flow %0d byte total", i),
                                    64'(rx_total[i]), 64'(tx_total[i]));
                    end
                end
            end
        end
        rst_q = rst;
    end

endmodule

// File: tests/echo_app_tb.sv
`timescale 1ns/1ps
module echo_app_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DELAY = 2;
    localparam int DRAIN_CYCLES = 200;
    localparam int NUM_ENTRIES = 28;
    localparam int STALL_ENTRY = 14;
    localparam int STALL_CYCLES = 30;

    typedef enum logic {
        KIND_NEW_FLOW = 1'b0,
        KIND_DATA     = 1'b1
    } stim_kind_e;

    typedef struct packed {
        stim_kind_e             kind;
        echo_noc_pkg::flowid_t  flowid;
        echo_noc_pkg::len_t     length;
        logic [7:0]             gap;
    } stim_t;

    logic clk;
    logic rst;
    logic new_flow_val;
    echo_noc_pkg::noc_data_t new_flow_data;
    logic new_flow_rdy;
    logic rx_data_val;
    echo_noc_pkg::noc_data_t rx_data_data;
    logic rx_data_rdy;
    logic tx_cmd_val;
    echo_noc_pkg::noc_data_t tx_cmd_data;
    logic tx_cmd_rdy;

    stim_t stim_table [NUM_ENTRIES];
    int num_loaded = 0;
    logic table_loaded = 1'b0;
    logic stall_go;
    logic final_check;
    logic [31:0] lcg_state = 32'h1770aca0;
    int check_count;
    int error_count;

    echo_app_top uut (
         .clk           (clk)
        ,.rst           (rst)
        ,.new_flow_val  (new_flow_val)
        ,.new_flow_data (new_flow_data)
        ,.new_flow_rdy  (new_flow_rdy)
        ,.rx_data_val   (rx_data_val)
        ,.rx_data_data  (rx_data_data)
        ,.rx_data_rdy   (rx_data_rdy)
        ,.tx_cmd_val    (tx_cmd_val)
        ,.tx_cmd_data   (tx_cmd_data)
        ,.tx_cmd_rdy    (tx_cmd_rdy)
    );

    echo_app_checker port_checker (
         .clk           (clk)
        ,.rst           (rst)
        ,.new_flow_val  (new_flow_val)
        ,.new_flow_data (new_flow_data)
        ,.new_flow_rdy  (new_flow_rdy)
        ,.rx_data_val   (rx_data_val)
        ,.rx_data_data  (rx_data_data)
        ,.rx_data_rdy   (rx_data_rdy)
        ,.tx_cmd_val    (tx_cmd_val)
        ,.tx_cmd_data   (tx_cmd_data)
        ,.tx_cmd_rdy    (tx_cmd_rdy)
        ,.final_check   (final_check)
        ,.check_count   (check_count)
        ,.error_count   (error_count)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic echo_noc_pkg::noc_data_t make_flit(input echo_noc_pkg::noc_msg_e msg,
                                                          input echo_noc_pkg::flowid_t flowid,
                                                          input echo_noc_pkg::len_t length);
        echo_noc_pkg::noc_hdr_flit_t hdr;
        hdr.msg_type = msg;
        hdr.flowid = flowid;
        hdr.length = length;
        hdr.padding = '0;
        return hdr;
    endfunction

    task automatic add_entry(input stim_kind_e kind, input int flowid, input int length,
                             input int gap);
        stim_table[num_loaded] = '{kind, flowid[3:0], length[15:0], gap[7:0]};
        num_loaded++;
    endtask

    // flows 1, 3, 5 and 9 are registered; flow 7 never is.
    task automatic load_table();
        add_entry(KIND_NEW_FLOW, 1, 0, 2);
        add_entry(KIND_NEW_FLOW, 3, 0, 1);
        add_entry(KIND_NEW_FLOW, 5, 0, 1);
        add_entry(KIND_NEW_FLOW, 9, 0, 1);
        add_entry(KIND_DATA, 1, 1200, 3);
        add_entry(KIND_DATA, 3, 640, 2);
        add_entry(KIND_DATA, 5, 64, 1);
        add_entry(KIND_DATA, 9, 1500, 4);
        add_entry(KIND_DATA, 7, 300, 1);
        add_entry(KIND_DATA, 1, 20, 0);
        add_entry(KIND_DATA, 3, 9000, 2);
        add_entry(KIND_DATA, 5, 1460, 5);
        add_entry(KIND_DATA, 1, 512, 1);
        add_entry(KIND_DATA, 9, 8, 0);
        add_entry(KIND_DATA, 3, 777, 1);
        add_entry(KIND_DATA, 5, 2048, 0);
        add_entry(KIND_DATA, 7, 1000, 1);
        add_entry(KIND_DATA, 1, 4096, 0);
        add_entry(KIND_DATA, 9, 333, 2);
        add_entry(KIND_DATA, 3, 12, 0);
        add_entry(KIND_DATA, 5, 900, 1);
        add_entry(KIND_DATA, 1, 65, 3);
        add_entry(KIND_DATA, 9, 30000, 2);
        add_entry(KIND_DATA, 7, 5, 4);
        add_entry(KIND_DATA, 3, 256, 1);
        add_entry(KIND_DATA, 5, 1, 6);
        add_entry(KIND_DATA, 9, 4000, 2);
        add_entry(KIND_DATA, 1, 1024, 8);
    endtask

    // rdy depends only on the receiver state, so it is steady from here to the edge.
    task automatic apply_entry(input stim_t e);
        repeat (e.gap) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        if (e.kind == KIND_NEW_FLOW) begin
            new_flow_data = make_flit(echo_noc_pkg::MSG_NEW_FLOW, e.flowid, e.length);
            new_flow_val = 1'b1;
            while (!new_flow_rdy) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            new_flow_val = 1'b0;
        end else begin
            rx_data_data = make_flit(echo_noc_pkg::MSG_RX_DATA, e.flowid, e.length);
            rx_data_val = 1'b1;
            while (!rx_data_rdy) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            rx_data_val = 1'b0;
        end
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // random back-pressure, low about a third of the time, plus one long stall.
    initial begin : drive_tx_rdy
        int stall_left;
        logic stall_taken;
        stall_left = 0;
        stall_taken = 1'b0;
        tx_cmd_rdy = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (stall_go && !stall_taken) begin
                stall_left = STALL_CYCLES;
                stall_taken = 1'b1;
            end
            if (stall_left > 0) begin
                tx_cmd_rdy = 1'b0;
                stall_left--;
            end else begin
                tx_cmd_rdy = ((next_random() >> 16) % 3) != 0;
            end
        end
    end

    initial begin : watchdog
        longint limit_cycles;
        wait (table_loaded);
        limit_cycles = DRAIN_CYCLES + 4 * NUM_ENTRIES;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            limit_cycles += stim_table[i].gap;
        end
        #(limit_cycles * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main
        rst = 1'b1;
        new_flow_val = 1'b0;
        new_flow_data = '0;
        rx_data_val = 1'b0;
        rx_data_data = '0;
        stall_go = 1'b0;
        final_check = 1'b0;
        load_table();
        table_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (i == STALL_ENTRY) begin
                stall_go <= 1'b1;
            end
            apply_entry(stim_table[i]);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        final_check = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        final_check = 1'b0;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
